// File: design/arp_cache.sv
`default_nettype none

module arp_cache #(
    parameter int CACHE_ADDR_WIDTH = 9
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        clear_cache,
    input  wire                        query_valid,
    input  wire arp_pkg::ip_addr_t     query_ip,
    output logic                       hit_valid,
    output logic                       hit_error,
    output arp_pkg::mac_addr_t         hit_mac,
    input  wire                        wr_valid,
    input  wire arp_pkg::cache_write_t wr
);

    localparam int DEPTH = 2 ** CACHE_ADDR_WIDTH;

    logic               valid_mem [DEPTH];
    arp_pkg::ip_addr_t  ip_mem    [DEPTH];
    arp_pkg::mac_addr_t mac_mem   [DEPTH];

    logic                        clearing;
    logic [CACHE_ADDR_WIDTH-1:0] clear_idx;
    logic [CACHE_ADDR_WIDTH-1:0] query_idx;
    logic [CACHE_ADDR_WIDTH-1:0] wr_idx;

    // direct mapped on the low ip bits
    assign query_idx = query_ip[CACHE_ADDR_WIDTH-1:0];
    assign wr_idx    = wr.ip[CACHE_ADDR_WIDTH-1:0];

    // invalidate walk of one entry per cycle
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            clearing  <= 1'b1;
            clear_idx <= '0;
        end else if (clearing) begin
            clear_idx <= clear_idx + 1'b1;
            if (&clear_idx) begin
                clearing <= 1'b0;
            end
        end
    end

    // writes landing during the walk are dropped
    always_ff @(posedge clk) begin
        if (clearing) begin
            valid_mem[clear_idx] <= 1'b0;
        end else if (wr_valid) begin
            valid_mem[wr_idx] <= 1'b1;
            ip_mem[wr_idx]    <= wr.ip;
            mac_mem[wr_idx]   <= wr.mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= query_valid;
        end
    end

    // tag compare that misses everything while the walk runs
    always_ff @(posedge clk) begin
        hit_error <= clearing || !valid_mem[query_idx] || (ip_mem[query_idx] != query_ip);
        hit_mac   <= mac_mem[query_idx];
    end

    // a write is visible to a query of the same ip on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        $past(wr_valid && !clearing) && !clearing && query_valid &&
        (query_ip == $past(wr.ip))
        |=> !hit_error && (hit_mac == $past(wr.mac, 2)));

endmodule

`default_nettype wire

// File: design/arp_config_regs.sv
`default_nettype none

module arp_config_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cfg_load,
    input  wire arp_pkg::arp_cfg_t cfg_in,
    output arp_pkg::arp_cfg_t      cfg
);

    // addresses steering the resolver, live from the cycle after the load
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_load) begin
            cfg <= cfg_in;
        end
    end

endmodule

`default_nettype wire

// File: design/arp_lookup_fsm.sv
`default_nettype none

module arp_lookup_fsm #(
    parameter int    RETRY_COUNT        = 4,
    parameter int    RETRY_INTERVAL_MS  = 2000,
    parameter int    REQUEST_TIMEOUT_MS = 30000,
    localparam int   MS_WIDTH = arp_pkg::ms_width(RETRY_INTERVAL_MS, REQUEST_TIMEOUT_MS)
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire arp_pkg::arp_cfg_t   cfg,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire arp_pkg::ip_addr_t   req_ip,
    output logic                     resp_valid,
    input  wire                      resp_ready,
    output logic                     resp_error,
    output arp_pkg::mac_addr_t       resp_mac,
    output logic                     query_valid,
    output arp_pkg::ip_addr_t        query_ip,
    input  wire                      hit_valid,
    input  wire                      hit_error,
    input  wire arp_pkg::mac_addr_t  hit_mac,
    output logic                     lookup_frame_valid,
    input  wire                      lookup_frame_ready,
    output arp_pkg::arp_frame_t      lookup_frame,
    output logic                     timer_load,
    output logic [MS_WIDTH-1:0]      timer_ms,
    input  wire                      timer_zero
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_QUERY,
        ST_RESOLVING,
        ST_RESPOND
    } lookup_state_e;

    localparam int CNT_WIDTH = $clog2(RETRY_COUNT + 1);

    lookup_state_e         state;
    arp_pkg::ip_addr_t     target_ip;
    logic [CNT_WIDTH-1:0]  sends_left;
    logic [CNT_WIDTH-1:0]  sends_next;
    logic                  on_subnet;
    logic                  is_bcast;
    logic                  hit;
    logic                  send_first;
    logic                  give_up;

    assign req_ready   = state == ST_IDLE;
    assign query_valid = (state == ST_QUERY) || (state == ST_RESOLVING);
    assign query_ip    = target_ip;

    // no bits differ from the gateway where the mask is set
    assign on_subnet = ((req_ip ^ cfg.gateway_ip) & cfg.subnet_mask) == '0;
    // limited broadcast, or every host bit set inside the subnet
    assign is_bcast  = (req_ip == arp_pkg::BROADCAST_IP) ||
                       (on_subnet && ((req_ip | cfg.subnet_mask) == arp_pkg::BROADCAST_IP));

    assign hit        = hit_valid && !hit_error;
    assign send_first = (state == ST_QUERY) && hit_valid && hit_error;
    assign give_up    = (state == ST_RESOLVING) && !hit && timer_zero && (sends_left == '0);
    assign timer_load = send_first ||
                        ((state == ST_RESOLVING) && !hit && timer_zero && (sends_left != '0));
    assign sends_next = send_first ? CNT_WIDTH'(RETRY_COUNT - 1) : sends_left - 1'b1;
    // after the last request only the long timeout is left
    assign timer_ms   = (sends_next != '0) ? MS_WIDTH'(RETRY_INTERVAL_MS)
                                           : MS_WIDTH'(REQUEST_TIMEOUT_MS);

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= ST_IDLE;
            resp_valid         <= 1'b0;
            lookup_frame_valid <= 1'b0;
            sends_left         <= '0;
        end else begin
            if (lookup_frame_ready) begin
                lookup_frame_valid <= 1'b0;
            end
            if (timer_load) begin
                lookup_frame_valid <= 1'b1;
                sends_left         <= sends_next;
            end
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state      <= is_bcast ? ST_RESPOND : ST_QUERY;
                        resp_valid <= is_bcast;
                    end
                end
                ST_QUERY: begin
                    if (hit_valid) begin
                        state      <= hit_error ? ST_RESOLVING : ST_RESPOND;
                        resp_valid <= !hit_error;
                    end
                end
                ST_RESOLVING: begin
                    if (hit || give_up) begin
                        state      <= ST_RESPOND;
                        resp_valid <= 1'b1;
                    end
                end
                ST_RESPOND: begin
                    if (resp_ready) begin
                        state      <= ST_IDLE;
                        resp_valid <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // off-subnet targets resolve through the gateway
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            target_ip  <= on_subnet ? req_ip : cfg.gateway_ip;
            resp_error <= 1'b0;
            resp_mac   <= arp_pkg::BROADCAST_MAC;
        end else if (query_valid && hit) begin
            resp_error <= 1'b0;
            resp_mac   <= hit_mac;
        end else if (give_up) begin
            resp_error <= 1'b1;
            resp_mac   <= arp_pkg::ZERO_MAC;
        end
        if (timer_load) begin
            lookup_frame <= '{eth_mac: arp_pkg::BROADCAST_MAC,
                              oper:    arp_pkg::OPER_ARP_REQUEST,
                              sha:     cfg.local_mac,
                              spa:     cfg.local_ip,
                              tha:     arp_pkg::ZERO_MAC,
                              tpa:     target_ip};
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(req_ready && resp_valid));

endmodule

`default_nettype wire

// File: design/arp_pkg.sv
`default_nettype none

package arp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // opcodes as carried in the arp oper field
    typedef enum logic [15:0] {
        OPER_ARP_REQUEST   = 16'h0001,
        OPER_ARP_REPLY     = 16'h0002,
        OPER_INARP_REQUEST = 16'h0008,
        OPER_INARP_REPLY   = 16'h0009
    } arp_oper_e;

    // parsed arp header plus the ethernet address of the far end
    typedef struct packed {
        mac_addr_t eth_mac;
        arp_oper_e oper;
        mac_addr_t sha;
        ip_addr_t  spa;
        mac_addr_t tha;
        ip_addr_t  tpa;
    } arp_frame_t;

    typedef struct packed {
        mac_addr_t local_mac;
        ip_addr_t  local_ip;
        ip_addr_t  gateway_ip;
        ip_addr_t  subnet_mask;
    } arp_cfg_t;

    typedef struct packed {
        ip_addr_t  ip;
        mac_addr_t mac;
    } cache_write_t;

    localparam mac_addr_t BROADCAST_MAC = 48'hffff_ffff_ffff;
    localparam ip_addr_t  BROADCAST_IP  = 32'hffff_ffff;
    localparam mac_addr_t ZERO_MAC      = 48'h0000_0000_0000;

    // width of a millisecond count able to hold the larger interval
    function automatic int ms_width(int interval_ms, int timeout_ms);
        int max_ms;
        max_ms = (interval_ms > timeout_ms) ? interval_ms : timeout_ms;
        return $clog2(max_ms + 1);
    endfunction

endpackage

`default_nettype wire

// File: design/arp_retry_timer.sv
`default_nettype none

module arp_retry_timer #(
    parameter int CYCLES_PER_MS = 125000,
    parameter int MS_WIDTH      = 15
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                timer_load,
    input  wire [MS_WIDTH-1:0] timer_ms,
    output logic               timer_zero
);

    localparam int PRESC_WIDTH = $clog2(CYCLES_PER_MS + 1);

    logic [PRESC_WIDTH-1:0] presc;
    logic [MS_WIDTH-1:0]    ms_left;
    logic                   ms_tick;

    assign ms_tick    = presc == PRESC_WIDTH'(CYCLES_PER_MS - 1);
    assign timer_zero = ms_left == '0;

    // a load restarts the prescaler so the first millisecond is whole
    always_ff @(posedge clk) begin
        if (rst) begin
            presc   <= '0;
            ms_left <= '0;
        end else if (timer_load) begin
            presc   <= '0;
            ms_left <= timer_ms;
        end else begin
            presc <= ms_tick ? '0 : presc + 1'b1;
            if (ms_tick && !timer_zero) begin
                ms_left <= ms_left - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/arp_rx_responder.sv
`default_nettype none

module arp_rx_responder (
    input  wire                        clk,
    input  wire                        rst,
    input  wire arp_pkg::arp_cfg_t     cfg,
    input  wire                        rx_valid,
    output logic                       rx_ready,
    input  wire arp_pkg::arp_frame_t   rx_frame,
    output logic                       wr_valid,
    output arp_pkg::cache_write_t      wr,
    output logic                       resp_frame_valid,
    input  wire                        resp_frame_ready,
    output arp_pkg::arp_frame_t        resp_frame
);

    logic accept;
    logic is_arp_req;
    logic is_inarp_req;

    assign accept       = rx_valid && rx_ready;
    assign is_arp_req   = (rx_frame.oper == arp_pkg::OPER_ARP_REQUEST) &&
                          (rx_frame.tpa == cfg.local_ip);
    assign is_inarp_req = (rx_frame.oper == arp_pkg::OPER_INARP_REQUEST) &&
                          (rx_frame.tha == cfg.local_mac);

    // rx is only open while the reply slot is free
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready         <= 1'b0;
            resp_frame_valid <= 1'b0;
            wr_valid         <= 1'b0;
        end else begin
            wr_valid <= accept;
            if (accept && (is_arp_req || is_inarp_req)) begin
                resp_frame_valid <= 1'b1;
                rx_ready         <= 1'b0;
            end else if (!resp_frame_valid || resp_frame_ready) begin
                resp_frame_valid <= 1'b0;
                rx_ready         <= 1'b1;
            end
        end
    end

    // learn the sender, answer with swapped address pairs
    always_ff @(posedge clk) begin
        if (accept) begin
            wr.ip  <= rx_frame.spa;
            wr.mac <= rx_frame.sha;
        end
        if (accept && (is_arp_req || is_inarp_req)) begin
            resp_frame.eth_mac <= rx_frame.eth_mac;
            resp_frame.oper    <= is_arp_req ? arp_pkg::OPER_ARP_REPLY
                                             : arp_pkg::OPER_INARP_REPLY;
            resp_frame.sha     <= cfg.local_mac;
            resp_frame.spa     <= cfg.local_ip;
            resp_frame.tha     <= rx_frame.sha;
            resp_frame.tpa     <= rx_frame.spa;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        resp_frame_valid && !resp_frame_ready |=> resp_frame_valid && $stable(resp_frame));

endmodule

`default_nettype wire

// File: design/arp_top.sv
`default_nettype none

module arp_top #(
    parameter int CACHE_ADDR_WIDTH   = 9,
    parameter int CYCLES_PER_MS      = 125000,
    parameter int RETRY_COUNT        = 4,
    parameter int RETRY_INTERVAL_MS  = 2000,
    parameter int REQUEST_TIMEOUT_MS = 30000
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rx_valid,
    output logic                     rx_ready,
    input  wire arp_pkg::arp_frame_t rx_frame,
    output logic                     tx_valid,
    input  wire                      tx_ready,
    output arp_pkg::arp_frame_t      tx_frame,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire arp_pkg::ip_addr_t   req_ip,
    output logic                     resp_valid,
    input  wire                      resp_ready,
    output logic                     resp_error,
    output arp_pkg::mac_addr_t       resp_mac,
    input  wire                      cfg_load,
    input  wire arp_pkg::arp_cfg_t   cfg_in,
    input  wire                      clear_cache
);

    localparam int MS_WIDTH = arp_pkg::ms_width(RETRY_INTERVAL_MS, REQUEST_TIMEOUT_MS);

    arp_pkg::arp_cfg_t     cfg;
    logic                  query_valid;
    arp_pkg::ip_addr_t     query_ip;
    logic                  hit_valid;
    logic                  hit_error;
    arp_pkg::mac_addr_t    hit_mac;
    logic                  wr_valid;
    arp_pkg::cache_write_t wr;
    logic                  resp_frame_valid;
    logic                  resp_frame_ready;
    arp_pkg::arp_frame_t   resp_frame;
    logic                  lookup_frame_valid;
    logic                  lookup_frame_ready;
    arp_pkg::arp_frame_t   lookup_frame;
    logic                  timer_load;
    logic [MS_WIDTH-1:0]   timer_ms;
    logic                  timer_zero;

    arp_config_regs config_regs_i (.*);

    arp_cache #(
        .CACHE_ADDR_WIDTH(CACHE_ADDR_WIDTH)
    ) cache_i (.*);

    arp_rx_responder rx_responder_i (.*);

    arp_lookup_fsm #(
        .RETRY_COUNT(RETRY_COUNT),
        .RETRY_INTERVAL_MS(RETRY_INTERVAL_MS),
        .REQUEST_TIMEOUT_MS(REQUEST_TIMEOUT_MS)
    ) lookup_fsm_i (.*);

    arp_retry_timer #(
        .CYCLES_PER_MS(CYCLES_PER_MS),
        .MS_WIDTH(MS_WIDTH)
    ) retry_timer_i (.*);

    arp_tx_arbiter tx_arbiter_i (.*);

endmodule

`default_nettype wire

// File: design/arp_tx_arbiter.sv
`default_nettype none

module arp_tx_arbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      resp_frame_valid,
    output logic                     resp_frame_ready,
    input  wire arp_pkg::arp_frame_t resp_frame,
    input  wire                      lookup_frame_valid,
    output logic                     lookup_frame_ready,
    input  wire arp_pkg::arp_frame_t lookup_frame,
    output logic                     tx_valid,
    input  wire                      tx_ready,
    output arp_pkg::arp_frame_t      tx_frame
);

    logic slot_open;

    // register empty or draining this cycle
    assign slot_open          = !tx_valid || tx_ready;
    // lookup requests go first
    assign lookup_frame_ready = slot_open;
    assign resp_frame_ready   = slot_open && !lookup_frame_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (slot_open) begin
            tx_valid <= lookup_frame_valid || resp_frame_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_open) begin
            tx_frame <= lookup_frame_valid ? lookup_frame : resp_frame;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
design/arp_pkg.sv
design/arp_config_regs.sv
design/arp_cache.sv
design/arp_rx_responder.sv
design/arp_lookup_fsm.sv
design/arp_retry_timer.sv
design/arp_tx_arbiter.sv
design/arp_top.sv
tb/arp_tb.sv

// File: tb/arp_tb.sv
`default_nettype none

module arp_tb;

    localparam int CACHE_ADDR_WIDTH   = 4;
    localparam int CYCLES_PER_MS      = 10;
    localparam int RETRY_COUNT        = 3;
    localparam int RETRY_INTERVAL_MS  = 2;
    localparam int REQUEST_TIMEOUT_MS = 4;
    localparam int TIMEOUT            = 400;
    localparam int SETTLE             = 8;

    typedef enum logic [2:0] {
        ROW_CONFIG,
        ROW_HOLD,
        ROW_CLEAR,
        ROW_RX,
        ROW_LOOKUP,
        ROW_INJECT
    } row_kind_e;

    // one stimulus step with what the model expects back
    typedef struct packed {
        row_kind_e           kind;
        arp_pkg::arp_frame_t frame;
        arp_pkg::ip_addr_t   ip;
        arp_pkg::mac_addr_t  exp_mac;
        logic                exp_error;
        logic [3:0]          exp_tx_count;
        arp_pkg::arp_frame_t exp_tx;
        logic [7:0]          hold_cycles;
    } row_t;

    logic                clk;
    logic                rst;
    logic                rx_valid;
    logic                rx_ready;
    arp_pkg::arp_frame_t rx_frame;
    logic                tx_valid;
    logic                tx_ready;
    arp_pkg::arp_frame_t tx_frame;
    logic                req_valid;
    logic                req_ready;
    arp_pkg::ip_addr_t   req_ip;
    logic                resp_valid;
    logic                resp_ready;
    logic                resp_error;
    arp_pkg::mac_addr_t  resp_mac;
    logic                cfg_load;
    arp_pkg::arp_cfg_t   cfg_in;
    logic                clear_cache;

    arp_pkg::arp_cfg_t   cfg_val;
    row_t                rows[$];
    arp_pkg::mac_addr_t  learned[arp_pkg::ip_addr_t];
    arp_pkg::arp_frame_t tx_seen[$];
    logic [31:0]         lfsr;
    int                  errors;
    int                  timeouts;
    logic                held_pending;
    arp_pkg::arp_frame_t held_frame;

    arp_top #(
        .CACHE_ADDR_WIDTH(CACHE_ADDR_WIDTH),
        .CYCLES_PER_MS(CYCLES_PER_MS),
        .RETRY_COUNT(RETRY_COUNT),
        .RETRY_INTERVAL_MS(RETRY_INTERVAL_MS),
        .REQUEST_TIMEOUT_MS(REQUEST_TIMEOUT_MS)
    ) dut_i (.*);

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at time %0t", what, $time);
        timeouts++;
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // reference model of the resolver rules
    function automatic logic on_subnet(input arp_pkg::ip_addr_t ip);
        return (ip & cfg_val.subnet_mask) == (cfg_val.gateway_ip & cfg_val.subnet_mask);
    endfunction

    function automatic logic is_broadcast(input arp_pkg::ip_addr_t ip);
        if (ip == 32'hffff_ffff) begin
            return 1'b1;
        end
        // every host bit set inside our subnet
        return on_subnet(ip) && ((ip & ~cfg_val.subnet_mask) == ~cfg_val.subnet_mask);
    endfunction

    function automatic arp_pkg::ip_addr_t target_of(input arp_pkg::ip_addr_t ip);
        return on_subnet(ip) ? ip : cfg_val.gateway_ip;
    endfunction

    function automatic logic wants_reply(input arp_pkg::arp_frame_t f);
        return (f.oper == arp_pkg::OPER_ARP_REQUEST && f.tpa == cfg_val.local_ip) ||
               (f.oper == arp_pkg::OPER_INARP_REQUEST && f.tha == cfg_val.local_mac);
    endfunction

    function automatic arp_pkg::arp_frame_t reply_for(input arp_pkg::arp_frame_t f);
        arp_pkg::arp_frame_t r;
        r.eth_mac = f.eth_mac;
        r.oper    = (f.oper == arp_pkg::OPER_ARP_REQUEST) ? arp_pkg::OPER_ARP_REPLY
                                                          : arp_pkg::OPER_INARP_REPLY;
        r.sha     = cfg_val.local_mac;
        r.spa     = cfg_val.local_ip;
        r.tha     = f.sha;
        r.tpa     = f.spa;
        return r;
    endfunction

    function automatic arp_pkg::arp_frame_t request_for(input arp_pkg::ip_addr_t ip);
        return '{eth_mac: 48'hffff_ffff_ffff, oper: arp_pkg::OPER_ARP_REQUEST,
                 sha: cfg_val.local_mac, spa: cfg_val.local_ip,
                 tha: 48'h0, tpa: ip};
    endfunction

    task automatic config_row();
        row_t r;
        r = '0;
        r.kind = ROW_CONFIG;
        rows.push_back(r);
    endtask

    task automatic hold_row(input int cycles);
        row_t r;
        r = '0;
        r.kind        = ROW_HOLD;
        r.hold_cycles = 8'(cycles);
        rows.push_back(r);
    endtask

    task automatic clear_row();
        row_t r;
        r = '0;
        r.kind = ROW_CLEAR;
        rows.push_back(r);
        learned.delete();
    endtask

    task automatic rx_row(input arp_pkg::arp_frame_t f);
        row_t r;
        r = '0;
        r.kind  = ROW_RX;
        r.frame = f;
        if (wants_reply(f)) begin
            r.exp_tx_count = 4'd1;
            r.exp_tx       = reply_for(f);
        end
        learned[f.spa] = f.sha;
        rows.push_back(r);
    endtask

    task automatic lookup_row(input arp_pkg::ip_addr_t ip);
        row_t              r;
        arp_pkg::ip_addr_t t;
        r = '0;
        r.kind = ROW_LOOKUP;
        r.ip   = ip;
        t      = target_of(ip);
        if (is_broadcast(ip)) begin
            r.exp_mac = 48'hffff_ffff_ffff;
        end else if (learned.exists(t)) begin
            r.exp_mac = learned[t];
        end else begin
            r.exp_error    = 1'b1;
            r.exp_tx_count = 4'(RETRY_COUNT);
            r.exp_tx       = request_for(t);
        end
        rows.push_back(r);
    endtask

    // miss answered by an injected frame after the first request
    task automatic inject_row(input arp_pkg::ip_addr_t ip, input arp_pkg::arp_frame_t f);
        row_t r;
        r = '0;
        r.kind         = ROW_INJECT;
        r.ip           = ip;
        r.frame        = f;
        r.exp_mac      = f.sha;
        r.exp_tx_count = 4'd1;
        r.exp_tx       = request_for(target_of(ip));
        learned[f.spa] = f.sha;
        rows.push_back(r);
    endtask

    task automatic build_table();
        arp_pkg::arp_frame_t f;
        config_row();
        // cache invalidate walk after reset
        hold_row(24);
        lookup_row(32'hffff_ffff);
        lookup_row(32'hc0a8_01ff);
        f = '{eth_mac: 48'h02_11_22_33_44_55, oper: arp_pkg::OPER_ARP_REQUEST,
              sha: 48'h02_11_22_33_44_55, spa: 32'hc0a8_0105,
              tha: 48'h0, tpa: cfg_val.local_ip};
        rx_row(f);
        // gateway asking for someone else
        f = '{eth_mac: 48'h02_aa_bb_cc_dd_01, oper: arp_pkg::OPER_ARP_REQUEST,
              sha: 48'h02_aa_bb_cc_dd_01, spa: 32'hc0a8_0101,
              tha: 48'h0, tpa: 32'hc0a8_0163};
        rx_row(f);
        f = '{eth_mac: 48'h02_77_66_55_44_33, oper: arp_pkg::OPER_INARP_REQUEST,
              sha: 48'h02_77_66_55_44_33, spa: 32'hc0a8_0107,
              tha: cfg_val.local_mac, tpa: 32'h0};
        rx_row(f);
        lookup_row(32'hc0a8_0105);
        lookup_row(32'h0a00_0001);
        lookup_row(32'hc0a8_0107);
        lookup_row(32'hc0a8_0109);
        clear_row();
        hold_row(24);
        f = '{eth_mac: 48'h02_de_ad_be_ef_01, oper: arp_pkg::OPER_ARP_REPLY,
              sha: 48'h02_de_ad_be_ef_01, spa: 32'hc0a8_0105,
              tha: cfg_val.local_mac, tpa: cfg_val.local_ip};
        inject_row(32'hc0a8_0105, f);
    endtask

    task automatic send_rx_frame(input arp_pkg::arp_frame_t f);
        int n;
        rx_valid = 1'b1;
        rx_frame = f;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (rx_ready) break;
        end
        if (n == TIMEOUT) report_timeout("rx_ready");
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic send_request(input arp_pkg::ip_addr_t ip);
        int n;
        req_valid = 1'b1;
        req_ip    = ip;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (req_ready) break;
        end
        if (n == TIMEOUT) report_timeout("req_ready");
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_response(input arp_pkg::mac_addr_t exp_mac, input logic exp_error);
        int                 n;
        arp_pkg::mac_addr_t mac;
        logic               err;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (resp_valid) break;
        end
        if (n == TIMEOUT) begin
            report_timeout("resp_valid");
            @(posedge clk);
            #1;
        end else begin
            assert (resp_error == exp_error) else report_error(
                $sformatf("resp_error got %0b, expected %0b", resp_error, exp_error));
            if (!exp_error) begin
                assert (resp_mac == exp_mac) else report_error(
                    $sformatf("resp_mac got %h, expected %h", resp_mac, exp_mac));
            end
            mac = resp_mac;
            err = resp_error;
            @(posedge clk);
            #1;
            resp_ready = 1'b1;
            @(negedge clk);
            assert (resp_valid && resp_mac == mac && resp_error == err) else
                report_error("response changed before resp_ready");
            @(posedge clk);
            #1;
            resp_ready = 1'b0;
        end
    endtask

    task automatic compare_tx_frames(input row_t r);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            if (tx_seen.size() >= r.exp_tx_count) break;
            @(posedge clk);
        end
        if (n == TIMEOUT) report_timeout("tx frames");
        // give stray frames a chance to show up
        repeat (SETTLE) @(posedge clk);
        #1;
        assert (tx_seen.size() == r.exp_tx_count) else report_error(
            $sformatf("%0d tx frames, expected %0d", tx_seen.size(), r.exp_tx_count));
        foreach (tx_seen[i]) begin
            assert (tx_seen[i] == r.exp_tx) else report_error(
                $sformatf("tx frame %0d got %h, expected %h", i, tx_seen[i], r.exp_tx));
        end
        tx_seen.delete();
    endtask

    task automatic apply_row(input row_t r);
        int n;
        case (r.kind)
            ROW_CONFIG: begin
                cfg_in   = cfg_val;
                cfg_load = 1'b1;
                @(posedge clk);
                #1;
                cfg_load = 1'b0;
            end
            ROW_HOLD: begin
                repeat (r.hold_cycles) @(posedge clk);
                #1;
            end
            ROW_CLEAR: begin
                clear_cache = 1'b1;
                @(posedge clk);
                #1;
                clear_cache = 1'b0;
            end
            ROW_RX: send_rx_frame(r.frame);
            ROW_LOOKUP: begin
                send_request(r.ip);
                wait_response(r.exp_mac, r.exp_error);
            end
            ROW_INJECT: begin
                send_request(r.ip);
                for (n = 0; n < TIMEOUT; n++) begin
                    @(negedge clk);
                    if (tx_valid) break;
                end
                if (n == TIMEOUT) report_timeout("the request frame on tx");
                @(posedge clk);
                #1;
                send_rx_frame(r.frame);
                wait_response(r.exp_mac, r.exp_error);
            end
            default: ;
        endcase
        compare_tx_frames(r);
    endtask

    // random back-pressure on tx
    always @(posedge clk) begin
        #1;
        lfsr     = lfsr_step(lfsr);
        tx_ready = lfsr[0];
    end

    // collect tx transfers and check that a stalled frame holds still
    always @(negedge clk) begin
        if (rst) begin
            held_pending = 1'b0;
        end else begin
            if (held_pending) begin
                assert (tx_valid && tx_frame == held_frame) else
                    report_error("tx frame changed while stalled");
            end
            if (tx_valid && tx_ready) begin
                tx_seen.push_back(tx_frame);
            end
            held_pending = tx_valid && !tx_ready;
            held_frame   = tx_frame;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rx_valid     = 1'b0;
        rx_frame     = '0;
        tx_ready     = 1'b0;
        req_valid    = 1'b0;
        req_ip       = '0;
        resp_ready   = 1'b0;
        cfg_load     = 1'b0;
        cfg_in       = '0;
        clear_cache  = 1'b0;
        lfsr         = 32'h264b_e56e;
        errors       = 0;
        timeouts     = 0;
        held_pending = 1'b0;
        cfg_val = '{local_mac: 48'h02_00_00_00_00_01, local_ip: 32'hc0a8_010a,
                    gateway_ip: 32'hc0a8_0101, subnet_mask: 32'hffff_ff00};
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
